// File: riscv_lsu.f
+incdir+design
design/lsu_mem_pkg.sv
design/lsu_op_pkg.sv
design/lsu_pend_if.sv
design/lsu_req_gen.sv
design/lsu_pend_fifo.sv
design/lsu_load_align.sv
design/lsu_top.sv
test/lsu_properties.sv
test/lsu_tb.sv

// File: test/lsu_tb.sv
// testbench for the load/store unit
// clock, reset, memory model with random grant and rvalid delays,
// directed and random accesses, load result checks, watchdog

module lsu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 8;
  localparam int N_ACCESS    = 83;  // 32 store, 24 load, 8 address, 4 refused, 12 stream, 3 err
  localparam int WDOG_CYCLES = 40 * N_ACCESS + 100;

  logic               clk, rst_n;
  logic               req_i, we_i, sign_ext_i, use_incr_i;
  lsu_op_pkg::size_e  size_i;
  lsu_mem_pkg::addr_t opa_i, opb_i, data_addr_o;
  lsu_mem_pkg::word_t wdata_i, load_data_o, data_wdata_o, data_rdata_i;
  logic [1:0]         reg_ofs_i;
  logic               ready_o, misaligned_o, load_err_o, store_err_o, load_valid_o, busy_o;
  logic               data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  lsu_mem_pkg::be_t   data_be_o;

  lsu_mem_pkg::word_t mem [64];  // memory model contents
  lsu_mem_pkg::word_t rd_q [$];  // read word per granted access
  int                 due_q [$]; // cycle of its rvalid
  int                 cyc, last_due, due, gnt_wait;
  logic [31:0]        mst;       // model random state
  logic               slow_rsp = 1'b0;
  lsu_mem_pkg::word_t exp_q [$]; // expected load results in issue order
  string              name_q [$];
  lsu_mem_pkg::word_t chk_exp;
  string              chk_name;
  int                 errors = 0, n_checks = 0, n_tests = 0, err_mark = 0;

  lsu_top i_dut (.*);

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // lane extraction and extension as loads define it
  function automatic logic [31:0] load_value(input logic [31:0] w, input lsu_op_pkg::size_e sz,
                                             input logic sx, input logic [1:0] ofs);
    logic [15:0] h;
    logic [7:0]  b;
    h = ofs[1] ? w[31:16] : w[15:0];
    b = w[8*ofs +: 8];
    case (sz)
      lsu_op_pkg::SZ_WORD: return w;
      lsu_op_pkg::SZ_HALF: return {{16{sx & h[15]}}, h};
      default:             return {{24{sx & b[7]}}, b};
    endcase
  endfunction

  function automatic logic [31:0] rot_bytes(input logic [31:0] w, input logic [1:0] n);
    return (w << (8 * n)) | (w >> (32 - 8 * n));  // left by n bytes
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      cyc      = 0;
      last_due = 0;
      gnt_wait = 0;
      mst      = 32'd12;
      rd_q.delete();
      due_q.delete();
    end
    else
    begin
      cyc = cyc + 1;
      if (data_rvalid_i)
      begin
        void'(rd_q.pop_front());
        void'(due_q.pop_front());
      end
      if (data_req_o && data_gnt_i)
      begin
        rd_q.push_back(mem[data_addr_o[7:2]]);  // read before a store lands
        for (int j = 0; j < 4; j++)
          if (data_we_o && data_be_o[j])
            mem[data_addr_o[7:2]][8*j +: 8] = data_wdata_o[8*j +: 8];
        mst = lcg(mst);
        due = cyc - 1 + (slow_rsp ? 3 : 1 + mst[25:24] % 3);  // 1 to 3 after grant
        if (due <= last_due)
          due = last_due + 1;  // keep rvalid in order
        last_due = due;
        due_q.push_back(due);
        gnt_wait = mst[17:16] % 3;  // next grant after 0 to 2 cycles
      end
      else if (data_req_o && gnt_wait != 0)
        gnt_wait = gnt_wait - 1;
    end
  end

  always @(negedge clk)
  begin
    data_gnt_i    = rst_n && (gnt_wait == 0);
    data_rvalid_i = rst_n && (due_q.size() != 0) && (due_q[0] <= cyc);
    data_rdata_i  = (rd_q.size() != 0) ? rd_q[0] : '0;
  end

  ////////////////////////////////////////////////////////////
  // checks and stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("ERR %s expected %h actual %h", name, exp_v, act_v);
    errors++;
  endtask

  always @(posedge clk)
  begin
    if (rst_n && load_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("load result arrived with no load outstanding");
        errors++;
      end
      else
      begin
        chk_exp  = exp_q.pop_front();
        chk_name = name_q.pop_front();
        n_checks++;
        if (load_data_o !== chk_exp)
          report_mismatch(chk_name, chk_exp, load_data_o);
      end
    end
  end

  task automatic issue_access(input string name, input logic we, input lsu_op_pkg::size_e sz,
                              input logic sx, input logic [31:0] a, input logic [31:0] b,
                              input logic incr, input logic [31:0] wd, input logic [1:0] rofs,
                              input logic err);
    logic [31:0] ea;
    logic [1:0]  ofs;
    logic        mis;
    logic [3:0]  exp_be;
    logic [31:0] mask;
    ea  = incr ? a + b : a;
    ofs = ea[1:0];
    mis = (sz == lsu_op_pkg::SZ_WORD && ofs != 2'd0)
          || (sz == lsu_op_pkg::SZ_HALF && ofs == 2'd3);
    @(negedge clk);
    req_i      = 1'b1;
    we_i       = we;
    size_i     = sz;
    sign_ext_i = sx;
    opa_i      = a;
    opb_i      = b;
    use_incr_i = incr;
    wdata_i    = wd;
    reg_ofs_i  = rofs;
    data_err_i = err;
    do @(posedge clk); while (!ready_o);  // held until done or refused
    n_checks++;
    if (mis)
    begin
      if (misaligned_o !== 1'b1 || data_req_o !== 1'b0)
      begin
        $display("%s: misaligned access at %h was not refused", name, ea);
        errors++;
      end
    end
    else if (!(data_req_o && data_gnt_i))
    begin
      $display("%s: access at %h finished without a grant", name, ea);
      errors++;
    end
    else
    begin
      if (data_addr_o !== ea)
        report_mismatch(name, ea, data_addr_o);
      if (data_we_o !== we)
        report_mismatch(name, we, data_we_o);
      if (err && (load_err_o !== !we || store_err_o !== we))
      begin
        $display("%s: error flag does not follow the access direction", name);
        errors++;
      end
      if (we)
      begin
        case (sz)
          lsu_op_pkg::SZ_WORD: exp_be = 4'b1111;
          lsu_op_pkg::SZ_HALF: exp_be = 4'b0011 << ofs;
          default:             exp_be = 4'b0001 << ofs;
        endcase
        mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
        if (data_be_o !== exp_be)
          report_mismatch(name, exp_be, data_be_o);
        if ((data_wdata_o & mask) !== (rot_bytes(wd, ofs - rofs) & mask))
          report_mismatch(name, rot_bytes(wd, ofs - rofs) & mask, data_wdata_o & mask);
      end
      else
      begin
        exp_q.push_back(load_value(mem[ea[7:2]], sz, sx, ofs));
        name_q.push_back(name);
      end
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    req_i      = 1'b0;
    data_err_i = 1'b0;
    do @(posedge clk); while (busy_o);  // every rvalid back
  endtask

  task automatic end_test(input string name);
    int n;
    wait_idle();
    @(negedge clk);  // lets this edge's assertions report first
    // idle unit owes no rvalid and no load result
    if (exp_q.size() != 0 || due_q.size() != 0)
    begin
      $display("%s: unit went idle with %0d load results and %0d rvalids still owed",
               name, exp_q.size(), due_q.size());
      errors++;
      exp_q.delete();
      name_q.delete();
    end
    n = errors + i_dut.u_props.fail_cnt - err_mark;
    $display("test %-12s %s, %0d failures", name, (n == 0) ? "ok" : "FAILED", n);
    err_mark = errors + i_dut.u_props.fail_cnt;
    n_tests++;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] tst;
    logic [31:0] a_v;
    int          total;
    rst_n         = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    size_i        = lsu_op_pkg::SZ_WORD;
    sign_ext_i    = 1'b0;
    opa_i         = '0;
    opb_i         = '0;
    use_incr_i    = 1'b0;
    wdata_i       = '0;
    reg_ofs_i     = '0;
    data_err_i    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    tst = 32'd12;
    for (int i = 0; i < 64; i++)
    begin
      tst    = lcg(tst);
      mem[i] = tst ^ i;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // every size, aligned offset and register offset
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 4; o++)
        for (int r = 0; r < 4; r++)
          if (!((s == 0 && o != 0) || (s == 1 && o == 3)))
          begin
            tst = lcg(tst);
            issue_access("store_lanes", 1'b1, lsu_op_pkg::size_e'(s), 1'b0,
                         32'h40 + 4 * r + o, '0, 1'b0, tst, r[1:0], 1'b0);
          end
    end_test("store_lanes");

    // both byte codes, zero and sign extension
    for (int s = 0; s < 4; s++)
      for (int o = 0; o < 4; o++)
        for (int x = 0; x < 2; x++)
          if (!((s == 0 && o != 0) || (s == 1 && o == 3)))
            issue_access("load_ext", 1'b0, lsu_op_pkg::size_e'(s), x[0],
                         32'h80 + 8 * s + 4 * x + o, '0, 1'b0, '0, 2'd0, 1'b0);
    end_test("load_ext");

    for (int i = 0; i < 8; i++)
    begin
      tst = lcg(tst);
      a_v = tst;
      tst = lcg(tst);
      issue_access("address", i[1], lsu_op_pkg::SZ_BYTE, i[0], a_v, tst, i[0],
                   a_v ^ tst, i[2:1], 1'b0);  // adder sees full random operands
    end
    end_test("address");

    issue_access("misaligned", 1'b0, lsu_op_pkg::SZ_WORD, 1'b0, 32'h101, '0, 1'b0, '0, 2'd0, 1'b0);
    issue_access("misaligned", 1'b1, lsu_op_pkg::SZ_WORD, 1'b0, 32'h100, 32'h2, 1'b1,
                 32'hcafe_f00d, 2'd0, 1'b0);
    issue_access("misaligned", 1'b0, lsu_op_pkg::SZ_WORD, 1'b0, 32'h103, '0, 1'b0, '0, 2'd0, 1'b0);
    issue_access("misaligned", 1'b1, lsu_op_pkg::SZ_HALF, 1'b0, 32'h107, '0, 1'b0, '0, 2'd3, 1'b0);
    end_test("misaligned");

    slow_rsp = 1'b1;  // rvalid 3 cycles late fills the buffer
    for (int i = 0; i < 12; i++)
      issue_access("stream", 1'b0, lsu_op_pkg::SZ_WORD, 1'b0, 32'hc0 + 4 * i, '0, 1'b0, '0,
                   2'd0, 1'b0);
    end_test("stream");
    slow_rsp = 1'b0;

    issue_access("err_flags", 1'b0, lsu_op_pkg::SZ_WORD, 1'b0, 32'h10, '0, 1'b0, '0, 2'd0, 1'b1);
    issue_access("err_flags", 1'b1, lsu_op_pkg::SZ_HALF, 1'b0, 32'h16, '0, 1'b0, 32'h1234,
                 2'd2, 1'b1);
    issue_access("err_flags", 1'b0, lsu_op_pkg::SZ_HALF, 1'b1, 32'h16, '0, 1'b0, '0, 2'd0, 1'b0);
    end_test("err_flags");

    total = errors + i_dut.u_props.fail_cnt;
    $display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
             n_tests, n_checks, errors, i_dut.u_props.fail_cnt);
    if (total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // watchdog, sized from the number of accesses
  initial
  begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, the DUT stopped completing accesses", WDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: test/lsu_properties.sv
// bound checker for the load/store unit top level
// request stability, outstanding limit, back-pressure,
// misaligned refusal, error flag direction, reset values

module lsu_properties
(
  input logic               clk,
  input logic               rst_n,
  input logic               req_i,
  input logic               ready_o,
  input logic               misaligned_o,
  input logic               load_err_o,
  input logic               store_err_o,
  input logic               load_valid_o,
  input logic               busy_o,
  input logic               data_req_o,
  input logic               data_gnt_i,
  input logic               data_rvalid_i,
  input logic               data_err_i,
  input logic               data_we_o,
  input lsu_mem_pkg::addr_t data_addr_o,
  input lsu_mem_pkg::be_t   data_be_o,
  input lsu_mem_pkg::word_t data_wdata_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // failed assertions, summed by the testbench
  logic [2:0]  outst;         // granted, still waiting for rvalid

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      outst <= '0;
    else
      outst <= outst + 3'(data_req_o && data_gnt_i) - 3'(data_rvalid_i);
  end

  ////////////////////////////////////////////////////////////
  // memory handshake
  ////////////////////////////////////////////////////////////

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_we_o)
      && $stable(data_be_o) && $stable(data_wdata_o))
    else
    begin
      fail_cnt++;
      $error("request dropped or changed before its grant");
    end

  // two entries at most, and no rvalid without a granted access
  a_outst_max: assert property (@(posedge clk) disable iff (!rst_n)
    outst <= 3'd2 && (!data_rvalid_i || outst != 3'd0))
    else
    begin
      fail_cnt++;
      $error("outstanding access count out of range");
    end

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    outst == 3'd2 && !data_rvalid_i |-> !data_req_o && (ready_o == (!req_i || misaligned_o)))
    else
    begin
      fail_cnt++;
      $error("request or ready raised while the buffer is full");
    end

  ////////////////////////////////////////////////////////////
  // core side flags
  ////////////////////////////////////////////////////////////

  a_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
    misaligned_o |-> !data_req_o && ready_o)
    else
    begin
      fail_cnt++;
      $error("misaligned access reached memory or stalled");
    end

  // err counts only with a grant, direction picks the flag
  a_err_flags: assert property (@(posedge clk) disable iff (!rst_n)
    load_err_o == (data_req_o && data_gnt_i && data_err_i && !data_we_o)
      && store_err_o == (data_req_o && data_gnt_i && data_err_i && data_we_o))
    else
    begin
      fail_cnt++;
      $error("load or store error flag wrong for the access");
    end

  a_reset: assert property (@(posedge clk)
    !rst_n |-> !(data_req_o || load_valid_o || busy_o || misaligned_o
                 || load_err_o || store_err_o))
    else
    begin
      fail_cnt++;
      $error("control output high during reset");
    end

endmodule

bind lsu_top lsu_properties u_props (.*);

// File: design/lsu_top.sv
// load/store unit top level
// plain core and memory ports, pending channel,
// request generator, pending buffer and load aligner

`include "lsu_consts.svh"

module lsu_top
(
  input  logic                  clk,
  input  logic                  rst_n,
  // core side
  input  logic                  req_i,
  input  logic                  we_i,
  input  lsu_op_pkg::size_e     size_i,
  input  logic                  sign_ext_i,
  input  lsu_mem_pkg::addr_t    opa_i,
  input  lsu_mem_pkg::addr_t    opb_i,
  input  logic                  use_incr_i,
  input  lsu_mem_pkg::word_t    wdata_i,
  input  logic [`LSU_OFS_W-1:0] reg_ofs_i,
  output logic                  ready_o,
  output logic                  misaligned_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output lsu_mem_pkg::word_t    load_data_o,
  output logic                  load_valid_o,
  output logic                  busy_o,
  // memory side
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  output lsu_mem_pkg::addr_t    data_addr_o,
  output logic                  data_we_o,
  output lsu_mem_pkg::be_t      data_be_o,
  output lsu_mem_pkg::word_t    data_wdata_o,
  input  lsu_mem_pkg::word_t    data_rdata_i
);

  logic fifo_busy;  // accesses still owed an rvalid

  lsu_pend_if pend_bus ();

  lsu_req_gen u_req_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .we_i         (we_i),
    .size_i       (size_i),
    .sign_ext_i   (sign_ext_i),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .use_incr_i   (use_incr_i),
    .wdata_i      (wdata_i),
    .reg_ofs_i    (reg_ofs_i),
    .data_gnt_i   (data_gnt_i),
    .data_err_i   (data_err_i),
    .data_req_o   (data_req_o),
    .data_addr_o  (data_addr_o),
    .data_we_o    (data_we_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .ready_o      (ready_o),
    .misaligned_o (misaligned_o),
    .load_err_o   (load_err_o),
    .store_err_o  (store_err_o),
    .pend         (pend_bus.push_mp)
  );

  lsu_pend_fifo u_pend_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy_o (fifo_busy),
    .pend   (pend_bus.store_mp)
  );

  // read word is decoded through the union inside the aligner
  lsu_load_align u_load_align (
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .load_data_o   (load_data_o),
    .load_valid_o  (load_valid_o),
    .pend          (pend_bus.pop_mp)
  );

  assign busy_o = fifo_busy || data_req_o;  // waiting on gnt or on rvalid

endmodule

// File: design/lsu_load_align.sv
// load side of the load/store unit
// pops the oldest access on rvalid, picks the lane
// and zero or sign extends the loaded value

`include "lsu_consts.svh"

module lsu_load_align
(
  input  logic                 data_rvalid_i,
  input  lsu_mem_pkg::rword_u  data_rdata_i,
  output lsu_mem_pkg::word_t   load_data_o,
  output logic                 load_valid_o,
  lsu_pend_if.pop_mp           pend
);

  lsu_op_pkg::pend_t head;    // access this rvalid answers
  logic [15:0]       half_v;  // selected halfword
  logic [7:0]        lane_v;  // selected byte

  assign head = pend.head_rec;

  // every rvalid retires one entry, stores included
  assign pend.pop     = data_rvalid_i && pend.head_valid;
  assign load_valid_o = pend.pop && !head.we;

  ////////////////////////////////////////////////////////////
  // lane select and extension
  ////////////////////////////////////////////////////////////

  assign half_v = data_rdata_i.half[head.ofs[`LSU_OFS_W-1]];  // upper offset bit
  assign lane_v = data_rdata_i.lane[head.ofs];

  always_comb
  begin
    case (head.size)
      lsu_op_pkg::SZ_WORD:
      begin
        load_data_o = data_rdata_i.word;  // aligned words pass as is
      end
      lsu_op_pkg::SZ_HALF:
      begin
        load_data_o = {{(`LSU_WORD_W-16){head.sign_ext && half_v[15]}}, half_v};
      end
      default:
      begin
        // both byte codes
        load_data_o = {{(`LSU_WORD_W-8){head.sign_ext && lane_v[7]}}, lane_v};
      end
    endcase
  end

endmodule

// File: design/lsu_pend_fifo.sv
// in-order buffer of granted accesses waiting for rvalid
// pointers, occupancy count, full and head outputs

`include "lsu_consts.svh"

module lsu_pend_fifo
(
  input  logic          clk,
  input  logic          rst_n,
  output logic          busy_o,
  lsu_pend_if.store_mp  pend
);

  localparam int DEPTH = `LSU_PEND_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_op_pkg::pend_t mem [DEPTH];  // records of granted accesses
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;        // entries held

  // wrap at DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (pend.push)
      mem[wr_ptr] <= pend.push_rec;  // slot of head is read before it is reused
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (pend.push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pend.pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({pend.push, pend.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign pend.full       = (count == CNT_W'(DEPTH));
  assign pend.head_valid = (count != '0);
  assign pend.head_rec   = mem[rd_ptr];
  assign busy_o          = pend.head_valid;  // something still owed an rvalid

endmodule

// File: design/lsu_req_gen.sv
// request side of the load/store unit
// address generation, alignment check, byte enables,
// write-data rotation, memory request and buffer push

`include "lsu_consts.svh"

module lsu_req_gen
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  we_i,
  input  lsu_op_pkg::size_e     size_i,
  input  logic                  sign_ext_i,
  input  lsu_mem_pkg::addr_t    opa_i,
  input  lsu_mem_pkg::addr_t    opb_i,
  input  logic                  use_incr_i,
  input  lsu_mem_pkg::word_t    wdata_i,
  input  logic [`LSU_OFS_W-1:0] reg_ofs_i,
  input  logic                  data_gnt_i,
  input  logic                  data_err_i,
  output logic                  data_req_o,
  output lsu_mem_pkg::addr_t    data_addr_o,
  output logic                  data_we_o,
  output lsu_mem_pkg::be_t      data_be_o,
  output lsu_mem_pkg::word_t    data_wdata_o,
  output logic                  ready_o,
  output logic                  misaligned_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  lsu_pend_if.push_mp           pend
);

  lsu_mem_pkg::addr_t    addr;    // effective address
  logic [`LSU_OFS_W-1:0] ofs;     // byte offset in the word
  logic [`LSU_OFS_W-1:0] rot;     // write lane rotation
  logic                  mis;     // refused access
  logic                  room;    // buffer can take a grant
  logic                  wait_q;  // request raised last cycle, no grant
  logic                  grant;   // request completes this cycle

  ////////////////////////////////////////////////////////////
  // address and alignment
  ////////////////////////////////////////////////////////////

  assign addr = use_incr_i ? (opa_i + opb_i) : opa_i;  // a+b or a alone
  assign ofs  = addr[`LSU_OFS_W-1:0];

  // word off boundary or half crossing the word is refused
  always_comb
  begin
    mis = 1'b0;
    if (req_i)
    begin
      case (size_i)
        lsu_op_pkg::SZ_WORD: mis = (ofs != '0);
        lsu_op_pkg::SZ_HALF: mis = (ofs == '1);
        default:             mis = 1'b0;  // bytes always fit
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // byte enables and write lanes
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      lsu_op_pkg::SZ_WORD: data_be_o = '1;
      lsu_op_pkg::SZ_HALF: data_be_o = lsu_mem_pkg::be_t'(2'b11) << ofs;
      default:             data_be_o = lsu_mem_pkg::be_t'(1'b1) << ofs;
    endcase
  end

  // register byte reg_ofs_i lands on address lane ofs
  assign rot = ofs - reg_ofs_i;

  always_comb
  begin
    case (rot)
      2'd0:    data_wdata_o = wdata_i;
      2'd1:    data_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    data_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: data_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // a request once raised stays up until its grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wait_q <= 1'b0;
    else
      wait_q <= data_req_o && !data_gnt_i;
  end

  assign room       = !pend.full || pend.pop;  // a pop frees a slot this cycle
  assign data_req_o = req_i && !mis && (room || wait_q);
  assign grant      = data_req_o && data_gnt_i;

  assign data_addr_o  = addr;
  assign data_we_o    = we_i;
  assign misaligned_o = mis;
  assign ready_o      = !req_i || mis || grant;  // idle, refused or done

  // grant cycle pushes what the load side will need
  assign pend.push     = grant;
  assign pend.push_rec = lsu_op_pkg::pend_t'{size:     size_i,
                                             ofs:      ofs,
                                             sign_ext: sign_ext_i,
                                             we:       we_i};

  // err only counts alongside the grant
  assign load_err_o  = grant && data_err_i && !we_i;
  assign store_err_o = grant && data_err_i && we_i;

endmodule

// File: design/lsu_pend_if.sv
// pending-access channel between request side, buffer and load side
// push side, store side and pop side modports

interface lsu_pend_if;

  logic              push;        // granted access enters the buffer
  lsu_op_pkg::pend_t push_rec;    // its record
  logic              full;        // no room left
  logic              head_valid;  // oldest entry present
  lsu_op_pkg::pend_t head_rec;    // oldest entry
  logic              pop;         // oldest entry answered by rvalid

  // request generator, needs pop to see room freed this cycle
  modport push_mp  (output push, output push_rec, input full, input pop);

  // buffer itself
  modport store_mp (input push, input push_rec, input pop,
                    output full, output head_valid, output head_rec);

  // load aligner
  modport pop_mp   (input head_valid, input head_rec, output pop);

endinterface

// File: design/lsu_op_pkg.sv
// operation-side types of the load/store unit
// access size codes and the record kept per granted access

`include "lsu_consts.svh"

package lsu_op_pkg;

  // access size, byte has two codes
  typedef enum logic [1:0] {
    SZ_WORD    = 2'd0,
    SZ_HALF    = 2'd1,
    SZ_BYTE    = 2'd2,
    SZ_BYTE_HI = 2'd3
  } size_e;

  // what the load side needs once rvalid comes back
  typedef struct packed {
    size_e                 size;      // access size
    logic [`LSU_OFS_W-1:0] ofs;       // byte offset of the address
    logic                  sign_ext;  // sign extend the loaded value
    logic                  we;        // store, no result returned
  } pend_t;

endpackage

// File: design/lsu_mem_pkg.sv
// memory-side types of the load/store unit
// byte address, data word, byte enables and the read-word union

`include "lsu_consts.svh"

package lsu_mem_pkg;

  // byte address on the data bus
  typedef logic [`LSU_WORD_W-1:0] addr_t;

  // one data word, read or write
  typedef logic [`LSU_WORD_W-1:0] word_t;

  // bit n enables bits 8n+7 .. 8n
  typedef logic [`LSU_WORD_W/8-1:0] be_t;

  // returned read word, decoded by lane or by halfword
  typedef union packed {
    word_t                                  word;  // whole word
    logic [`LSU_WORD_W/8-1:0][7:0]          lane;  // indexed by byte offset
    logic [`LSU_WORD_W/16-1:0][15:0]        half;  // indexed by offset bit 1
  } rword_u;

endpackage

// File: design/lsu_consts.svh
// sizing macros shared by the load/store unit
// word width, byte offset width, outstanding access depth

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_WORD_W 32

// byte offset inside a word
`define LSU_OFS_W 2

// granted accesses that may wait for rvalid
`define LSU_PEND_DEPTH 2

`endif
